// File: source/isa_pkg.sv
package isa_pkg;

  // ----------------------------------------------------------------------
  // Datapath and instruction widths
  // ----------------------------------------------------------------------
  localparam int unsigned ILEN = 32;
  localparam int unsigned CLEN = 16;
  localparam int unsigned XLEN = 32;

  // Instruction field widths
  localparam int unsigned REG_W    = 5;
  localparam int unsigned OPCODE_W = 7;
  localparam int unsigned FUNCT3_W = 3;
  localparam int unsigned FUNCT7_W = 7;

  typedef logic [REG_W-1:0] reg_idx_t;

  // ----------------------------------------------------------------------
  // Major opcodes of the supported RV32I subset
  // ----------------------------------------------------------------------
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  // Compressed quadrant and funct3 of the supported RVC encodings
  localparam logic [4:0] RVC_LW   = 5'b00_010;
  localparam logic [4:0] RVC_SW   = 5'b00_110;
  localparam logic [4:0] RVC_ADDI = 5'b01_000;
  localparam logic [4:0] RVC_LI   = 5'b01_010;
  localparam logic [4:0] RVC_LUI  = 5'b01_011;
  localparam logic [4:0] RVC_J    = 5'b01_101;
  localparam logic [4:0] RVC_BEQZ = 5'b01_110;
  localparam logic [4:0] RVC_BNEZ = 5'b01_111;
  localparam logic [4:0] RVC_CR   = 5'b10_100;

  // funct7 values that select SUB and SRA/SRAI
  localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

endpackage

// File: source/decode_pkg.sv
package decode_pkg;

  // Issue width, the issue buffer is built for exactly two slots
  localparam int unsigned NR_PORTS = 2;

  // ----------------------------------------------------------------------
  // Decoded operation
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    FU_NONE      = 3'd0,
    FU_ALU       = 3'd1,
    FU_CTRL_FLOW = 3'd2,
    FU_LOAD      = 3'd3,
    FU_STORE     = 3'd4
  } fu_t;

  // Loads, stores and jumps use ADD for the address sum
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_XOR  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_AND  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_t;

  // ----------------------------------------------------------------------
  // Stage payloads
  // ----------------------------------------------------------------------
  // A compressed instruction sits in the lower half of instruction
  typedef struct packed {
    logic [isa_pkg::XLEN-1:0] address;
    logic [isa_pkg::ILEN-1:0] instruction;
  } fetch_entry_t;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0] pc;
    fu_t                      fu;
    alu_op_t                  op;
    isa_pkg::reg_idx_t        rs1;
    isa_pkg::reg_idx_t        rs2;
    isa_pkg::reg_idx_t        rd;
    logic [isa_pkg::XLEN-1:0] imm;
    logic                     illegal;
    logic                     is_compressed;
  } sb_entry_t;

  typedef struct packed {
    logic                     valid;
    sb_entry_t                sbe;
    logic [isa_pkg::ILEN-1:0] orig_instr;
    logic                     is_ctrl_flow;
  } issue_slot_t;

endpackage

// File: source/compressed_expander.sv
`timescale 1ns/1ps

module compressed_expander #(
  parameter bit RvcEn = 1'b1
) (
  input  logic [isa_pkg::ILEN-1:0] instr_i,
  output logic [isa_pkg::ILEN-1:0] instr_o,
  output logic                     illegal_o,
  output logic                     is_compressed_o
);
  import isa_pkg::*;

  logic [CLEN-1:0] c;
  logic            compressed;

  // Full register fields of the CI/CR formats
  reg_idx_t rd_full;
  reg_idx_t rs2_full;
  // Three-bit fields of the CL/CS/CB formats, mapped to x8-x15
  reg_idx_t rs1_c;
  reg_idx_t rs2_c;

  assign c          = instr_i[CLEN-1:0];
  assign compressed = (c[1:0] != 2'b11);

  assign rd_full  = c[11:7];
  assign rs2_full = c[6:2];
  assign rs1_c    = {2'b01, c[9:7]};
  assign rs2_c    = {2'b01, c[4:2]};

  assign is_compressed_o = compressed;

  // ----------------------------------------------------------------------
  // Expansion to the 32-bit equivalent
  // ----------------------------------------------------------------------
  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (compressed) begin
      if (!RvcEn) begin
        illegal_o = 1'b1;
      end else begin
        case ({c[1:0], c[15:13]})
          RVC_LW: begin
            // lw rd', uimm(rs1')
            instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1_c, 3'b010, rs2_c, OPC_LOAD};
          end
          RVC_SW: begin
            // sw rs2', uimm(rs1')
            instr_o = {5'b0, c[5], c[12], rs2_c, rs1_c, 3'b010, c[11:10], c[6], 2'b00,
                       OPC_STORE};
          end
          RVC_ADDI: begin
            instr_o = {{7{c[12]}}, c[6:2], rd_full, 3'b000, rd_full, OPC_OP_IMM};
          end
          RVC_LI: begin
            instr_o = {{7{c[12]}}, c[6:2], 5'b0, 3'b000, rd_full, OPC_OP_IMM};
          end
          RVC_LUI: begin
            // rd == x2 is C.ADDI16SP, not in the supported set
            if (rd_full == 5'd2 || {c[12], c[6:2]} == 6'b0) begin
              illegal_o = 1'b1;
            end else begin
              instr_o = {{14{c[12]}}, c[12], c[6:2], rd_full, OPC_LUI};
            end
          end
          RVC_J: begin
            // jal x0, offset with the scrambled offset bits put back in J order
            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'b0, OPC_JAL};
          end
          RVC_BEQZ, RVC_BNEZ: begin
            // beq/bne rs1', x0, offset
            instr_o = {{4{c[12]}}, c[6:5], c[2], 5'b0, rs1_c, 2'b00, c[13],
                       c[11:10], c[4:3], c[12], OPC_BRANCH};
          end
          RVC_CR: begin
            if (!c[12]) begin
              if (rs2_full == 5'd0) begin
                // C.JR, rs1 == x0 is reserved
                if (rd_full == 5'd0) begin
                  illegal_o = 1'b1;
                end else begin
                  instr_o = {12'b0, rd_full, 3'b000, 5'b0, OPC_JALR};
                end
              end else begin
                // C.MV
                instr_o = {7'b0, rs2_full, 5'b0, 3'b000, rd_full, OPC_OP};
              end
            end else begin
              // C.EBREAK and C.JALR are not supported
              if (rs2_full == 5'd0) begin
                illegal_o = 1'b1;
              end else begin
                instr_o = {7'b0, rs2_full, rd_full, 3'b000, rd_full, OPC_OP};
              end
            end
          end
          default: begin
            illegal_o = 1'b1;
          end
        endcase
      end

      // Illegal encodings go on unchanged
      if (illegal_o) begin
        instr_o = instr_i;
      end
    end
  end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic [isa_pkg::XLEN-1:0] pc_i,
  input  logic [isa_pkg::ILEN-1:0] instr_i,
  input  logic [isa_pkg::ILEN-1:0] raw_instr_i,
  input  logic                     illegal_i,
  input  logic                     is_compressed_i,
  output decode_pkg::sb_entry_t    entry_o,
  output logic [isa_pkg::ILEN-1:0] orig_instr_o,
  output logic                     is_ctrl_flow_o
);
  import isa_pkg::*;
  import decode_pkg::*;

  opcode_t             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  logic                illegal;
  logic                ctrl_flow;

  // Sign-extended immediates of each format
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] shamt;

  assign opcode = opcode_t'(instr_i[OPCODE_W-1:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  assign shamt = {27'b0, instr_i[24:20]};

  // Compressed words keep only their 16 bits
  assign orig_instr_o = is_compressed_i ? {{(ILEN-CLEN){1'b0}}, raw_instr_i[CLEN-1:0]}
                                        : raw_instr_i;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  always_comb begin
    entry_o               = '0;
    entry_o.pc            = pc_i;
    entry_o.is_compressed = is_compressed_i;
    entry_o.fu            = FU_NONE;
    entry_o.op            = ALU_ADD;
    illegal               = 1'b0;
    ctrl_flow             = 1'b0;

    case (opcode)
      OPC_LUI, OPC_AUIPC: begin
        entry_o.fu  = FU_ALU;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_u;
      end
      OPC_JAL: begin
        entry_o.fu  = FU_CTRL_FLOW;
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_j;
        ctrl_flow   = 1'b1;
      end
      OPC_JALR: begin
        entry_o.fu  = FU_CTRL_FLOW;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_i;
        ctrl_flow   = 1'b1;
        illegal     = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        entry_o.fu  = FU_CTRL_FLOW;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_b;
        ctrl_flow   = 1'b1;
        case (funct3)
          3'b000:  entry_o.op = ALU_EQ;
          3'b001:  entry_o.op = ALU_NE;
          3'b100:  entry_o.op = ALU_LT;
          3'b101:  entry_o.op = ALU_GE;
          3'b110:  entry_o.op = ALU_LTU;
          3'b111:  entry_o.op = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // Access width stays in orig_instr
        entry_o.fu  = FU_LOAD;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_i;
        illegal     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        entry_o.fu  = FU_STORE;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.imm = imm_s;
        illegal     = (funct3[2] || funct3 == 3'b011);
      end
      OPC_OP_IMM: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rd  = instr_i[11:7];
        entry_o.imm = imm_i;
        case (funct3)
          3'b000: entry_o.op = ALU_ADD;
          3'b010: entry_o.op = ALU_SLT;
          3'b011: entry_o.op = ALU_SLTU;
          3'b100: entry_o.op = ALU_XOR;
          3'b110: entry_o.op = ALU_OR;
          3'b111: entry_o.op = ALU_AND;
          3'b001: begin
            entry_o.op  = ALU_SLL;
            entry_o.imm = shamt;
            illegal     = (funct7 != F7_BASE);
          end
          default: begin
            entry_o.op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            entry_o.imm = shamt;
            illegal     = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
        endcase
      end
      OPC_OP: begin
        entry_o.fu  = FU_ALU;
        entry_o.rs1 = instr_i[19:15];
        entry_o.rs2 = instr_i[24:20];
        entry_o.rd  = instr_i[11:7];
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: entry_o.op = ALU_ADD;
          {F7_ALT,  3'b000}: entry_o.op = ALU_SUB;
          {F7_BASE, 3'b001}: entry_o.op = ALU_SLL;
          {F7_BASE, 3'b010}: entry_o.op = ALU_SLT;
          {F7_BASE, 3'b011}: entry_o.op = ALU_SLTU;
          {F7_BASE, 3'b100}: entry_o.op = ALU_XOR;
          {F7_BASE, 3'b101}: entry_o.op = ALU_SRL;
          {F7_ALT,  3'b101}: entry_o.op = ALU_SRA;
          {F7_BASE, 3'b110}: entry_o.op = ALU_OR;
          {F7_BASE, 3'b111}: entry_o.op = ALU_AND;
          default:           illegal = 1'b1;
        endcase
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // An illegal entry carries only its pc and flags
    if (illegal || illegal_i) begin
      entry_o               = '0;
      entry_o.pc            = pc_i;
      entry_o.is_compressed = is_compressed_i;
      entry_o.fu            = FU_NONE;
      entry_o.op            = ALU_ADD;
      entry_o.illegal       = 1'b1;
      ctrl_flow             = 1'b0;
    end
  end

  assign is_ctrl_flow_o = ctrl_flow;

endmodule

// File: source/issue_buffer.sv
`timescale 1ns/1ps

module issue_buffer (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             flush_i,
  input  decode_pkg::issue_slot_t [decode_pkg::NR_PORTS-1:0] cand_i,
  input  logic                    [decode_pkg::NR_PORTS-1:0] fetch_valid_i,
  input  logic                    [decode_pkg::NR_PORTS-1:0] issue_ack_i,
  output logic                    [decode_pkg::NR_PORTS-1:0] fetch_ready_o,
  output decode_pkg::issue_slot_t [decode_pkg::NR_PORTS-1:0] slot_o
);
  import decode_pkg::*;

  issue_slot_t [NR_PORTS-1:0] slot_d;
  issue_slot_t [NR_PORTS-1:0] slot_q;

  // ----------------------------------------------------------------------
  // Next slot state
  // ----------------------------------------------------------------------
  always_comb begin
    slot_d        = slot_q;
    fetch_ready_o = '0;

    // Retire acknowledged slots
    if (issue_ack_i[0]) begin
      slot_d[0].valid = 1'b0;
    end
    if (issue_ack_i[1]) begin
      slot_d[1].valid = 1'b0;
    end

    // Keep the older entry in slot 0
    if (!slot_d[0].valid && slot_d[1].valid) begin
      slot_d[0]       = slot_d[1];
      slot_d[1].valid = 1'b0;
    end

    // Refill slot 0 from the older fetch port
    if (!slot_d[0].valid && fetch_valid_i[0]) begin
      fetch_ready_o[0] = 1'b1;
      slot_d[0]        = cand_i[0];
    end

    // Refill slot 1 from the next fetch entry in order
    if (!slot_d[1].valid) begin
      if (fetch_ready_o[0]) begin
        if (fetch_valid_i[1]) begin
          fetch_ready_o[1] = 1'b1;
          slot_d[1]        = cand_i[1];
        end
      end else if (fetch_valid_i[0]) begin
        fetch_ready_o[0] = 1'b1;
        slot_d[1]        = cand_i[0];
      end
    end

    // Flush drops everything and takes nothing
    if (flush_i) begin
      fetch_ready_o   = '0;
      slot_d[0].valid = 1'b0;
      slot_d[1].valid = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Slot registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_q <= '0;
    end else begin
      slot_q <= slot_d;
    end
  end

  assign slot_o = slot_q;

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage #(
  parameter bit RvcEn = 1'b1
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic                                               flush_i,
  // Fetch side, port 0 holds the older instruction
  input  decode_pkg::fetch_entry_t [decode_pkg::NR_PORTS-1:0] fetch_entry_i,
  input  logic                     [decode_pkg::NR_PORTS-1:0] fetch_valid_i,
  output logic                     [decode_pkg::NR_PORTS-1:0] fetch_ready_o,
  // Issue side, slot 0 holds the older entry
  output decode_pkg::issue_slot_t  [decode_pkg::NR_PORTS-1:0] issue_slot_o,
  input  logic                     [decode_pkg::NR_PORTS-1:0] issue_ack_i
);
  import decode_pkg::*;

  logic [NR_PORTS-1:0][isa_pkg::ILEN-1:0] exp_instr;
  logic [NR_PORTS-1:0]                    exp_illegal;
  logic [NR_PORTS-1:0]                    exp_compressed;
  issue_slot_t [NR_PORTS-1:0]             cand;

  // ----------------------------------------------------------------------
  // Decode lanes
  // ----------------------------------------------------------------------
  for (genvar i = 0; i < NR_PORTS; i++) begin : gen_lane
    compressed_expander #(
      .RvcEn(RvcEn)
    ) u_expander (
      .instr_i         (fetch_entry_i[i].instruction),
      .instr_o         (exp_instr[i]),
      .illegal_o       (exp_illegal[i]),
      .is_compressed_o (exp_compressed[i])
    );

    instr_decoder u_decoder (
      .pc_i            (fetch_entry_i[i].address),
      .instr_i         (exp_instr[i]),
      .raw_instr_i     (fetch_entry_i[i].instruction),
      .illegal_i       (exp_illegal[i]),
      .is_compressed_i (exp_compressed[i]),
      .entry_o         (cand[i].sbe),
      .orig_instr_o    (cand[i].orig_instr),
      .is_ctrl_flow_o  (cand[i].is_ctrl_flow)
    );

    // Every decoded entry is issuable, illegal ones included
    assign cand[i].valid = 1'b1;
  end

  // ----------------------------------------------------------------------
  // Decode/issue register
  // ----------------------------------------------------------------------
  issue_buffer u_issue_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .cand_i        (cand),
    .fetch_valid_i (fetch_valid_i),
    .issue_ack_i   (issue_ack_i),
    .fetch_ready_o (fetch_ready_o),
    .slot_o        (issue_slot_o)
  );

endmodule

// File: test/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
  import decode_pkg::*;

  localparam int NUM_VEC    = 24;
  localparam int FIELDS     = 11;
  localparam int MAX_CYCLES = 40 * NUM_VEC + 100;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        flush;
  fetch_entry_t [NR_PORTS-1:0] fetch_entry;
  logic [NR_PORTS-1:0]         fetch_valid;
  logic [NR_PORTS-1:0]         fetch_ready;
  issue_slot_t [NR_PORTS-1:0]  issue_slot;
  logic [NR_PORTS-1:0]         issue_ack;

  // Golden vectors with FIELDS words per instruction
  logic [31:0] gold [0:NUM_VEC*FIELDS-1];
  logic [31:0] lfsr;
  // Vector indices that should sit in slot 0 and slot 1
  int          exp_q[$];
  int          mismatch_errors;
  int          order_errors;
  int          checked;
  int          flushes;

  id_stage #(
    .RvcEn(1'b1)
  ) UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush),
    .fetch_entry_i (fetch_entry),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .issue_slot_o  (issue_slot),
    .issue_ack_i   (issue_ack)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic fetch_entry_t entry_for(input int idx);
    fetch_entry_t e;
    e = '0;
    if (idx < NUM_VEC) begin
      e.address     = gold[idx*FIELDS+1];
      e.instruction = gold[idx*FIELDS];
    end
    return e;
  endfunction

  task automatic compare_field(input string name, input int idx, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %0t: vector %0d %s is %h, expected %h", $time, idx, name, got, exp);
      mismatch_errors++;
    end
  endtask

  task automatic check_slot(input issue_slot_t s, input int idx);
    int          base;
    logic [31:0] exp_orig;
    base = idx * FIELDS;
    // A compressed word keeps only its low half
    exp_orig = gold[base+9][0] ? {16'h0000, gold[base][15:0]} : gold[base];
    compare_field("pc", idx, s.sbe.pc, gold[base+1]);
    compare_field("fu", idx, {29'b0, s.sbe.fu}, gold[base+2]);
    compare_field("op", idx, {28'b0, s.sbe.op}, gold[base+3]);
    compare_field("rs1", idx, {27'b0, s.sbe.rs1}, gold[base+4]);
    compare_field("rs2", idx, {27'b0, s.sbe.rs2}, gold[base+5]);
    compare_field("rd", idx, {27'b0, s.sbe.rd}, gold[base+6]);
    compare_field("imm", idx, s.sbe.imm, gold[base+7]);
    compare_field("illegal", idx, {31'b0, s.sbe.illegal}, gold[base+8]);
    compare_field("is_compressed", idx, {31'b0, s.sbe.is_compressed}, gold[base+9]);
    compare_field("is_ctrl_flow", idx, {31'b0, s.is_ctrl_flow}, gold[base+10]);
    compare_field("orig_instr", idx, s.orig_instr, exp_orig);
    checked++;
  endtask

  // Slot valids and order must match the outstanding entries exactly
  task automatic check_occupancy();
    for (int i = 0; i < NR_PORTS; i++) begin
      if (issue_slot[i].valid !== (exp_q.size() > i)) begin
        $display("Fail %0t: slot %0d valid is %b with %0d entries outstanding",
                 $time, i, issue_slot[i].valid, exp_q.size());
        order_errors++;
      end else if (issue_slot[i].valid && issue_slot[i].sbe.pc !== gold[exp_q[i]*FIELDS+1]) begin
        $display("Fail %0t: slot %0d holds pc %h, expected vector %0d",
                 $time, i, issue_slot[i].sbe.pc, exp_q[i]);
        order_errors++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus and checking
  // ----------------------------------------------------------------------
  initial begin
    int                  next_idx;
    int                  pass;
    int                  cycles;
    bit                  done;
    bit                  timed_out;
    bit                  flush_now;
    bit                  ack0;
    bit                  ack1;
    bit                  offer0;
    bit                  offer1;
    logic [31:0]         r;
    logic [NR_PORTS-1:0] ret;
    logic [NR_PORTS-1:0] acc;
    logic [NR_PORTS-1:0] exp_ready;

    $readmemh("test/id_stage_golden.txt", gold);
    lfsr            = 32'ha2c506eb;
    mismatch_errors = 0;
    order_errors    = 0;
    checked         = 0;
    flushes         = 0;
    next_idx        = 0;
    pass            = 0;
    cycles          = 0;
    done            = 1'b0;
    timed_out       = 1'b0;
    rst_ni          = 1'b0;
    flush           = 1'b0;
    fetch_entry     = '0;
    fetch_valid     = '0;
    issue_ack       = '0;

    repeat (3) begin
      @(negedge clk_i);
      if (issue_slot[0].valid !== 1'b0 || issue_slot[1].valid !== 1'b0) begin
        $display("Fail %0t: a slot is valid during reset", $time);
        order_errors++;
      end
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;

    while (!done && !timed_out) begin
      @(posedge clk_i);
      cycles++;
      check_occupancy();

      // Retire acknowledged slots in age order
      ret = issue_ack & {issue_slot[1].valid, issue_slot[0].valid};
      for (int i = 0; i < NR_PORTS; i++) begin
        if (ret[i] && exp_q.size() > i) begin
          check_slot(issue_slot[i], exp_q[i]);
        end
      end
      for (int i = 0; i < NR_PORTS; i++) begin
        if (ret[i] && exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end

      // Ready follows the slots left free after retirement
      exp_ready = '0;
      if (!flush) begin
        if (exp_q.size() < NR_PORTS) begin
          exp_ready[0] = fetch_valid[0];
        end
        if (exp_q.size() == 0) begin
          exp_ready[1] = fetch_valid[1] && fetch_valid[0];
        end
      end
      if (fetch_ready !== exp_ready) begin
        $display("Fail %0t: fetch_ready is %b, expected %b", $time, fetch_ready, exp_ready);
        order_errors++;
      end

      if (flush) begin
        exp_q.delete();
      end

      // Entries taken this cycle join the queue in port order
      acc = fetch_valid & fetch_ready;
      if (acc[0]) begin
        exp_q.push_back(next_idx);
        next_idx++;
        if (acc[1]) begin
          exp_q.push_back(next_idx);
          next_idx++;
        end
      end

      // Second pass repeats the file with flushes mixed in
      if (next_idx >= NUM_VEC && exp_q.size() == 0) begin
        if (pass == 0) begin
          pass     = 1;
          next_idx = 0;
        end else begin
          done = 1'b1;
        end
      end
      if (cycles >= MAX_CYCLES) begin
        $display("Timeout after %0d cycles, vector %0d of %0d not yet issued",
                 cycles, next_idx, NUM_VEC);
        timed_out = 1'b1;
      end

      draw_bits(4, r);
      flush_now = (pass == 1) && (r == 0);
      draw_bits(1, r);
      ack0 = !flush_now && exp_q.size() > 0 && r[0];
      draw_bits(1, r);
      ack1 = ack0 && exp_q.size() > 1 && r[0];
      draw_bits(2, r);
      offer0 = (next_idx < NUM_VEC) && (r != 0);
      draw_bits(1, r);
      offer1 = offer0 && (next_idx + 1 < NUM_VEC) && r[0];
      if (flush_now) begin
        flushes++;
      end

      flush          <= flush_now;
      issue_ack      <= {ack1, ack0};
      fetch_valid    <= {offer1, offer0};
      fetch_entry[0] <= entry_for(next_idx);
      fetch_entry[1] <= entry_for(next_idx + 1);
    end

    $display("Errors: %0d field mismatches, %0d order errors, %0d vectors checked, %0d flushes",
             mismatch_errors, order_errors, checked, flushes);
    if (!timed_out && mismatch_errors == 0 && order_errors == 0 && checked >= NUM_VEC) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: test/id_stage_golden.txt
// instr address fu op rs1 rs2 rd imm illegal is_compressed is_ctrl_flow, all hex
// fu 0 none 1 alu 2 ctrl 3 load 4 store, upper half of a compressed word is ignored
00500093 00001000 1 0 0 0 1 00000005 0 0 0  // addi x1, x0, 5
002081b3 00001004 1 0 1 2 3 00000000 0 0 0  // add x3, x1, x2
407302b3 00001008 1 1 6 7 5 00000000 0 0 0  // sub x5, x6, x7
12345537 0000100c 1 0 0 0 a 12345000 0 0 0  // lui x10, 0x12345
ffc12583 00001010 3 0 2 0 b fffffffc 0 0 0  // lw x11, -4(x2)
00c6a423 00001014 4 0 d c 0 00000008 0 0 0  // sw x12, 8(x13)
fe208ce3 00001018 2 a 1 2 0 fffffff8 0 0 1  // beq x1, x2, -8
010000ef 0000101c 2 0 0 0 1 00000010 0 0 1  // jal x1, 16
00008067 00001020 2 0 1 0 0 00000000 0 0 1  // jalr x0, 0(x1)
40325213 00001024 1 7 4 0 4 00000003 0 0 0  // srai x4, x4, 3
ffffffff 00001028 0 0 0 0 0 00000000 1 0 0  // unknown opcode
023100b3 0000102c 0 0 0 0 0 00000000 1 0 0  // mul, no M extension
dead147d 00001030 1 0 8 0 8 ffffffff 0 1 0  // c.addi x8, -1
0000449d 00001032 1 0 0 0 9 00000007 0 1 0  // c.li x9, 7
00006505 00001034 1 0 0 0 a 00001000 0 1 0  // c.lui x10, 1
000085b2 00001036 1 0 0 c b 00000000 0 1 0  // c.mv x11, x12
000096ba 00001038 1 0 d e d 00000000 0 1 0  // c.add x13, x14
0000bff5 0000103a 2 0 0 0 0 fffffffc 0 1 1  // c.j -4
0000e481 0000103c 2 b 9 0 0 00000008 0 1 1  // c.bnez x9, 8
00004048 0000103e 3 0 8 0 a 00000004 0 1 0  // c.lw x10, 4(x8)
0000c444 00001040 4 0 8 9 0 0000000c 0 1 0  // c.sw x9, 12(x8)
00008082 00001042 2 0 1 0 0 00000000 0 1 1  // c.jr x1
00009002 00001044 0 0 0 0 0 00000000 1 1 0  // c.ebreak, unsupported
12340506 00001046 0 0 0 0 0 00000000 1 1 0  // c.slli x10, 1, unsupported

// File: filelist.f
source/isa_pkg.sv
source/decode_pkg.sv
source/compressed_expander.sv
source/instr_decoder.sv
source/issue_buffer.sv
source/id_stage.sv
test/tb_id_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_id_stage
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
